/* verilog/rv_fe_pkg.sv */
// RV32I front end definitions
package rv_fe_pkg;

  localparam int XLEN       = 32;
  localparam int PC_WD      = 32;
  localparam int INST_WD    = 32;
  localparam int REG_IDX_WD = 5;

  localparam logic [PC_WD-1:0] PC_RESET = 32'h8000_0000; // first fetch address.

  // major opcodes, bits 6:0 of the instruction.
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  typedef enum logic [3:0] {
    OPC_CLS_ALU_REG,
    OPC_CLS_ALU_IMM,
    OPC_CLS_LOAD,
    OPC_CLS_STORE,
    OPC_CLS_BRANCH,
    OPC_CLS_JAL,
    OPC_CLS_JALR,
    OPC_CLS_UPPER,
    OPC_CLS_SYSTEM,
    OPC_CLS_ILLEGAL
  } op_class_e;

  typedef enum logic [2:0] {
    IMM_NONE,
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J
  } imm_fmt_e;

  // redirect from decode to the program counter.
  typedef struct packed {
    logic             br_taken;
    logic [PC_WD-1:0] br_target;
  } br_bus_t;

  typedef struct packed {
    logic [INST_WD-1:0] inst;
    logic [PC_WD-1:0]   pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic [PC_WD-1:0]      pc;
    logic [INST_WD-1:0]    inst;
    op_class_e             op_class;
    logic [REG_IDX_WD-1:0] rd;
    logic [REG_IDX_WD-1:0] rs1;
    logic [REG_IDX_WD-1:0] rs2;
    logic [XLEN-1:0]       imm;
    logic                  rd_wen;
  } dec_t;

endpackage

/* verilog/rv_pc.sv */
// Program counter
`timescale 1ns/10ps

module rv_pc (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  logic                        i_load,
  input  rv_fe_pkg::br_bus_t          i_br_bus,
  output logic [rv_fe_pkg::PC_WD-1:0] o_pc
);

  logic [rv_fe_pkg::PC_WD-1:0] pc_q;
  logic [rv_fe_pkg::PC_WD-1:0] pc_seq;
  logic [rv_fe_pkg::PC_WD-1:0] pc_next;

  assign pc_seq = pc_q + 32'd4;

  // a taken jal from decode overrides the sequential address.
  assign pc_next = i_br_bus.br_taken ? i_br_bus.br_target : pc_seq;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q <= rv_fe_pkg::PC_RESET;
    end else if (i_load) begin
      pc_q <= pc_next; // load happens at the end of the data cycle.
    end
  end

  assign o_pc = pc_q;

  // the redirect target comes from decode, so alignment is checked at the register.
  a_pc_aligned : assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_pc[1:0] == 2'b00
  ) else $error("rv_pc: misaligned pc %h", o_pc);

endmodule

/* verilog/rv_if_stage.sv */
// Instruction fetch stage
`timescale 1ns/10ps

module rv_if_stage (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  logic [rv_fe_pkg::PC_WD-1:0]   i_pc,
  output logic                          o_pc_load,
  // to decode
  output logic                          o_fs_to_ds_valid,
  output rv_fe_pkg::fs_to_ds_t          o_fs_to_ds_bus,
  // instruction sram port
  output logic                          o_inst_sram_en,
  output logic [rv_fe_pkg::PC_WD-1:0]   o_inst_sram_addr,
  input  logic [rv_fe_pkg::INST_WD-1:0] i_inst_sram_rdata
);

  logic fs_req;   // request strobe, high in the request cycle.
  logic fs_phase; // fetch phase flag, 1 in the data cycle.

  // Both flags start low so the first request lands one cycle after reset is released.
  // From then on the request and data cycles alternate.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      fs_req   <= 1'b0;
      fs_phase <= 1'b0;
    end else begin
      fs_req   <= ~fs_req;
      fs_phase <= fs_req; // data follows the strobe by one cycle.
    end
  end

  assign o_inst_sram_en   = fs_req;
  assign o_inst_sram_addr = i_pc;

  // the pc is held across the fetch, so it still matches the returned word.
  assign o_fs_to_ds_valid = fs_phase;
  assign o_fs_to_ds_bus   = '{inst: i_inst_sram_rdata, pc: i_pc};

  assign o_pc_load = fs_phase; // advance the pc at the end of the data cycle.

  a_req_data_excl : assert property (
    @(posedge i_clk) disable iff (i_rst)
    !(o_inst_sram_en && o_fs_to_ds_valid)
  ) else $error("rv_if_stage: strobe and valid high together");

  // the returned word is tagged with i_pc, so the pc must not move before the data cycle.
  a_req_then_data : assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_inst_sram_en |=> (o_fs_to_ds_valid && $stable(i_pc))
  ) else $error("rv_if_stage: no valid or pc changed after sram strobe");

endmodule

/* verilog/rv_imm_gen.sv */
// Immediate generator
`timescale 1ns/10ps

module rv_imm_gen (
  input  logic [rv_fe_pkg::INST_WD-1:0] i_inst,
  input  rv_fe_pkg::imm_fmt_e           i_fmt,
  output logic [rv_fe_pkg::XLEN-1:0]    o_imm
);

  logic [rv_fe_pkg::XLEN-1:0] imm_i;
  logic [rv_fe_pkg::XLEN-1:0] imm_s;
  logic [rv_fe_pkg::XLEN-1:0] imm_b;
  logic [rv_fe_pkg::XLEN-1:0] imm_u;
  logic [rv_fe_pkg::XLEN-1:0] imm_j;
  logic                       sign;

  assign sign = i_inst[31]; // all formats extend from bit 31.

  assign imm_i = {{20{sign}}, i_inst[31:20]};

  assign imm_s = {{20{sign}}, i_inst[31:25], i_inst[11:7]};

  // B and J scatter their fields and drop bit 0.
  assign imm_b = {
    {19{sign}},
    i_inst[31],
    i_inst[7],
    i_inst[30:25],
    i_inst[11:8],
    1'b0
  };

  assign imm_u = {i_inst[31:12], 12'b0};

  assign imm_j = {
    {11{sign}},
    i_inst[31],
    i_inst[19:12],
    i_inst[20],
    i_inst[30:21],
    1'b0
  };

  always_comb begin
    case (i_fmt)
      rv_fe_pkg::IMM_I: begin
        o_imm = imm_i;
      end
      rv_fe_pkg::IMM_S: begin
        o_imm = imm_s;
      end
      rv_fe_pkg::IMM_B: begin
        o_imm = imm_b;
      end
      rv_fe_pkg::IMM_U: begin
        o_imm = imm_u;
      end
      rv_fe_pkg::IMM_J: begin
        o_imm = imm_j;
      end
      default: begin
        o_imm = '0; // register forms and illegal opcodes carry no immediate.
      end
    endcase
  end

endmodule

/* verilog/rv_id_stage.sv */
// Instruction decode stage
`timescale 1ns/10ps

module rv_id_stage (
  input  logic                 i_clk,
  input  logic                 i_rst,
  // from fetch
  input  logic                 i_fs_to_ds_valid,
  input  rv_fe_pkg::fs_to_ds_t i_fs_to_ds_bus,
  // redirect to the pc
  output rv_fe_pkg::br_bus_t   o_br_bus,
  // decoded record
  output logic                 o_dec_valid,
  output rv_fe_pkg::dec_t      o_dec
);

  logic [rv_fe_pkg::INST_WD-1:0]    inst;
  logic [rv_fe_pkg::PC_WD-1:0]      pc;
  logic [6:0]                       opcode;
  rv_fe_pkg::op_class_e             op_class;
  rv_fe_pkg::imm_fmt_e              imm_fmt;
  logic [rv_fe_pkg::XLEN-1:0]       imm;
  logic [rv_fe_pkg::REG_IDX_WD-1:0] rd;
  logic [rv_fe_pkg::REG_IDX_WD-1:0] rs1;
  logic [rv_fe_pkg::REG_IDX_WD-1:0] rs2;
  logic                             rd_wen;
  logic [rv_fe_pkg::PC_WD-1:0]      jal_target;
  logic                             dec_valid_q;
  rv_fe_pkg::dec_t                  dec_q;

  assign inst   = i_fs_to_ds_bus.inst;
  assign pc     = i_fs_to_ds_bus.pc;
  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  // Every major opcode ends in 2'b11, so compressed encodings fall to the default.
  always_comb begin
    case (opcode)
      rv_fe_pkg::OPC_LUI, rv_fe_pkg::OPC_AUIPC: begin
        op_class = rv_fe_pkg::OPC_CLS_UPPER;
        imm_fmt  = rv_fe_pkg::IMM_U;
      end
      rv_fe_pkg::OPC_JAL: begin
        op_class = rv_fe_pkg::OPC_CLS_JAL;
        imm_fmt  = rv_fe_pkg::IMM_J;
      end
      rv_fe_pkg::OPC_JALR: begin
        op_class = rv_fe_pkg::OPC_CLS_JALR;
        imm_fmt  = rv_fe_pkg::IMM_I;
      end
      rv_fe_pkg::OPC_BRANCH: begin
        op_class = rv_fe_pkg::OPC_CLS_BRANCH;
        imm_fmt  = rv_fe_pkg::IMM_B;
      end
      rv_fe_pkg::OPC_LOAD: begin
        op_class = rv_fe_pkg::OPC_CLS_LOAD;
        imm_fmt  = rv_fe_pkg::IMM_I;
      end
      rv_fe_pkg::OPC_STORE: begin
        op_class = rv_fe_pkg::OPC_CLS_STORE;
        imm_fmt  = rv_fe_pkg::IMM_S;
      end
      rv_fe_pkg::OPC_OP_IMM: begin
        op_class = rv_fe_pkg::OPC_CLS_ALU_IMM;
        imm_fmt  = rv_fe_pkg::IMM_I;
      end
      rv_fe_pkg::OPC_OP: begin
        op_class = rv_fe_pkg::OPC_CLS_ALU_REG;
        imm_fmt  = rv_fe_pkg::IMM_NONE;
      end
      rv_fe_pkg::OPC_SYSTEM: begin
        op_class = rv_fe_pkg::OPC_CLS_SYSTEM;
        imm_fmt  = rv_fe_pkg::IMM_I; // csr number sits in the I field.
      end
      default: begin
        op_class = rv_fe_pkg::OPC_CLS_ILLEGAL;
        imm_fmt  = rv_fe_pkg::IMM_NONE;
      end
    endcase
  end

  always_comb begin
    case (op_class)
      rv_fe_pkg::OPC_CLS_ALU_REG, rv_fe_pkg::OPC_CLS_ALU_IMM, rv_fe_pkg::OPC_CLS_LOAD,
      rv_fe_pkg::OPC_CLS_JAL, rv_fe_pkg::OPC_CLS_JALR, rv_fe_pkg::OPC_CLS_UPPER: begin
        rd_wen = (rd != '0); // x0 is never written.
      end
      default: begin
        rd_wen = 1'b0;
      end
    endcase
  end

  rv_imm_gen u_imm_gen (
    .i_inst (inst),
    .i_fmt  (imm_fmt),
    .o_imm  (imm)
  );

  // for a jal the format is J, so the shared immediate is the jump offset.
  assign jal_target = pc + imm;
  assign o_br_bus   = '{
    br_taken:  i_fs_to_ds_valid && (op_class == rv_fe_pkg::OPC_CLS_JAL),
    br_target: jal_target
  };

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      dec_valid_q <= 1'b0;
    end else begin
      dec_valid_q <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid) begin
      dec_q <= '{pc: pc, inst: inst, op_class: op_class, rd: rd, rs1: rs1,
                 rs2: rs2, imm: imm, rd_wen: rd_wen};
    end
  end

  assign o_dec_valid = dec_valid_q;
  assign o_dec       = dec_q;

  // fetch takes two cycles per word, so records never arrive back to back.
  a_dec_spaced : assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_dec_valid |=> !o_dec_valid
  ) else $error("rv_id_stage: decode valid on consecutive cycles");

endmodule

/* verilog/rv_frontend.sv */
// RV32I front end top
`timescale 1ns/10ps

module rv_frontend (
  input  logic                          i_clk,
  input  logic                          i_rst,
  // instruction sram port
  output logic                          o_inst_sram_en,
  output logic [rv_fe_pkg::PC_WD-1:0]   o_inst_sram_addr,
  input  logic [rv_fe_pkg::INST_WD-1:0] i_inst_sram_rdata,
  // decoded output
  output logic                          o_dec_valid,
  output rv_fe_pkg::dec_t               o_dec
);

  logic [rv_fe_pkg::PC_WD-1:0] pc;
  logic                        pc_load;
  logic                        fs_to_ds_valid;
  rv_fe_pkg::fs_to_ds_t        fs_to_ds_bus;
  rv_fe_pkg::br_bus_t          br_bus;

  rv_pc u_pc (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_load   (pc_load),
    .i_br_bus (br_bus),
    .o_pc     (pc)
  );

  rv_if_stage u_if_stage (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_pc              (pc),
    .o_pc_load         (pc_load),
    .o_fs_to_ds_valid  (fs_to_ds_valid),
    .o_fs_to_ds_bus    (fs_to_ds_bus),
    .o_inst_sram_en    (o_inst_sram_en),
    .o_inst_sram_addr  (o_inst_sram_addr),
    .i_inst_sram_rdata (i_inst_sram_rdata)
  );

  // the branch bus closes the loop back to the pc within the data cycle.
  rv_id_stage u_id_stage (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_fs_to_ds_valid (fs_to_ds_valid),
    .i_fs_to_ds_bus   (fs_to_ds_bus),
    .o_br_bus         (br_bus),
    .o_dec_valid      (o_dec_valid),
    .o_dec            (o_dec)
  );

endmodule

/* bench/inst_sram_model.sv */
// Instruction SRAM model
`timescale 1ns/10ps

module inst_sram_model (
  input  logic        i_clk,
  input  logic        i_en,
  input  logic [31:0] i_addr,
  output logic [31:0] o_rdata
);

  // 1024 words, indexed by address bits 11:2, so the array mirrors
  // over the whole address space.
  logic [31:0] mem [0:1023];

  initial begin
    o_rdata = '0;
  end

  // synchronous read with one cycle of latency.
  always @(posedge i_clk) begin
    if (i_en) begin
      o_rdata <= #2 mem[i_addr[11:2]]; // returned data lags the edge like any tb drive.
    end
  end

endmodule

/* bench/tb_rv_frontend.sv */
// RV32I front end testbench
`timescale 1ns/10ps

module tb_rv_frontend;

  localparam int NUM_RECORDS = 400;
  localparam int MAX_CYCLES  = 2 * NUM_RECORDS + 200; // two cycles per fetch plus margin.

  logic            clk;
  logic            rst;
  logic            sram_en;
  logic [31:0]     sram_addr;
  logic [31:0]     sram_rdata;
  logic            dec_valid;
  rv_fe_pkg::dec_t dec;

  logic [31:0] image [0:1023];
  logic [31:0] lcg_state;
  logic [31:0] req_pc;   // model pc for the next sram request.
  logic [31:0] dec_pc;   // model pc for the next decoded record.
  logic [31:0] word;
  logic [31:0] exp_imm;
  rv_fe_pkg::op_class_e exp_cls;
  int errors;
  int records;
  int cycles;
  int post_cyc;

  rv_frontend rv_frontend_inst (
    .i_clk             (clk),
    .i_rst             (rst),
    .o_inst_sram_en    (sram_en),
    .o_inst_sram_addr  (sram_addr),
    .i_inst_sram_rdata (sram_rdata),
    .o_dec_valid       (dec_valid),
    .o_dec             (dec)
  );

  inst_sram_model u_sram (
    .i_clk   (clk),
    .i_en    (sram_en),
    .i_addr  (sram_addr),
    .o_rdata (sram_rdata)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // about one word in eight is a jal, one in sixteen is illegal.
  function automatic logic [31:0] build_word();
    logic [31:0] rnd;
    logic [31:0] sel;
    logic [6:0]  opc;
    logic [31:0] w;
    rnd = lcg_next();
    sel = lcg_next();
    case (sel[19:16])
      4'd0, 4'd1: opc = rv_fe_pkg::OPC_JAL;
      4'd2: begin
        case (sel[29:28])
          2'd0: opc = 7'b0001011;
          2'd1: opc = 7'b1111111;
          default: opc = {sel[6:2], 1'b0, sel[0]}; // low bits not 11.
        endcase
      end
      default: begin
        case (sel[27:20] % 9)
          0: opc = rv_fe_pkg::OPC_LUI;
          1: opc = rv_fe_pkg::OPC_AUIPC;
          2: opc = rv_fe_pkg::OPC_JALR;
          3: opc = rv_fe_pkg::OPC_BRANCH;
          4: opc = rv_fe_pkg::OPC_LOAD;
          5: opc = rv_fe_pkg::OPC_STORE;
          6: opc = rv_fe_pkg::OPC_OP_IMM;
          7: opc = rv_fe_pkg::OPC_OP;
          default: opc = rv_fe_pkg::OPC_SYSTEM;
        endcase
      end
    endcase
    w = {rnd[31:7], opc};
    if (opc == rv_fe_pkg::OPC_JAL) begin
      w[21] = 1'b0; // keeps the jump target word aligned.
    end
    return w;
  endfunction

  function automatic rv_fe_pkg::op_class_e expected_class(input logic [31:0] w);
    if (w[1:0] != 2'b11) return rv_fe_pkg::OPC_CLS_ILLEGAL;
    if (w[6:0] == rv_fe_pkg::OPC_OP) return rv_fe_pkg::OPC_CLS_ALU_REG;
    if (w[6:0] == rv_fe_pkg::OPC_OP_IMM) return rv_fe_pkg::OPC_CLS_ALU_IMM;
    if (w[6:0] == rv_fe_pkg::OPC_LOAD) return rv_fe_pkg::OPC_CLS_LOAD;
    if (w[6:0] == rv_fe_pkg::OPC_STORE) return rv_fe_pkg::OPC_CLS_STORE;
    if (w[6:0] == rv_fe_pkg::OPC_BRANCH) return rv_fe_pkg::OPC_CLS_BRANCH;
    if (w[6:0] == rv_fe_pkg::OPC_JAL) return rv_fe_pkg::OPC_CLS_JAL;
    if (w[6:0] == rv_fe_pkg::OPC_JALR) return rv_fe_pkg::OPC_CLS_JALR;
    if (w[6:0] == rv_fe_pkg::OPC_LUI || w[6:0] == rv_fe_pkg::OPC_AUIPC) begin
      return rv_fe_pkg::OPC_CLS_UPPER;
    end
    if (w[6:0] == rv_fe_pkg::OPC_SYSTEM) return rv_fe_pkg::OPC_CLS_SYSTEM;
    return rv_fe_pkg::OPC_CLS_ILLEGAL;
  endfunction

  function automatic logic [31:0] expected_imm(input logic [31:0] w,
                                               input rv_fe_pkg::op_class_e cls);
    logic signed [31:0] imm_i;
    logic signed [12:0] imm_b;
    logic signed [20:0] imm_j;
    logic [31:0]        res;
    imm_i = $signed(w) >>> 20;
    imm_b = {w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {w[31], w[19:12], w[20], w[30:21], 1'b0};
    case (cls)
      rv_fe_pkg::OPC_CLS_UPPER: res = {w[31:12], 12'h000};
      rv_fe_pkg::OPC_CLS_JAL: res = $signed(imm_j);
      rv_fe_pkg::OPC_CLS_BRANCH: res = $signed(imm_b);
      rv_fe_pkg::OPC_CLS_STORE: res = {imm_i[31:5], w[11:7]};
      rv_fe_pkg::OPC_CLS_ALU_IMM, rv_fe_pkg::OPC_CLS_LOAD,
      rv_fe_pkg::OPC_CLS_JALR, rv_fe_pkg::OPC_CLS_SYSTEM: res = imm_i;
      default: res = 32'h0;
    endcase
    return res;
  endfunction

  function automatic logic writes_rd(input logic [31:0] w, input rv_fe_pkg::op_class_e cls);
    if (w[11:7] == 5'd0) return 1'b0;
    return cls inside {rv_fe_pkg::OPC_CLS_ALU_REG, rv_fe_pkg::OPC_CLS_ALU_IMM,
                       rv_fe_pkg::OPC_CLS_LOAD, rv_fe_pkg::OPC_CLS_JAL,
                       rv_fe_pkg::OPC_CLS_JALR, rv_fe_pkg::OPC_CLS_UPPER};
  endfunction

  function automatic logic [31:0] next_fetch_pc(input logic [31:0] pc);
    logic [31:0] w;
    w = image[pc[11:2]];
    if (expected_class(w) == rv_fe_pkg::OPC_CLS_JAL) begin
      return pc + expected_imm(w, rv_fe_pkg::OPC_CLS_JAL);
    end
    return pc + 32'd4;
  endfunction

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  always @(posedge clk) begin
    cycles++;
  end

  // outputs are sampled at the falling edge, well away from the drive times.
  always @(negedge clk) begin
    if (rst) begin
      if (cycles > 0) begin
        compare_field("o_inst_sram_en", sram_en, 1'b0);
        compare_field("o_dec_valid", dec_valid, 1'b0);
      end
    end else begin
      compare_field("o_inst_sram_en", sram_en, post_cyc % 2);
      compare_field("o_dec_valid", dec_valid, (post_cyc % 2 == 1) && post_cyc >= 3);
      if (sram_en) begin
        compare_field("o_inst_sram_addr", sram_addr, req_pc);
        req_pc = next_fetch_pc(req_pc);
      end
      if (dec_valid) begin
        word    = image[dec_pc[11:2]];
        exp_cls = expected_class(word);
        exp_imm = expected_imm(word, exp_cls);
        compare_field("o_dec.pc", dec.pc, dec_pc);
        compare_field("o_dec.inst", dec.inst, word);
        compare_field("o_dec.op_class", dec.op_class, exp_cls);
        compare_field("o_dec.rd", dec.rd, word[11:7]);
        compare_field("o_dec.rs1", dec.rs1, word[19:15]);
        compare_field("o_dec.rs2", dec.rs2, word[24:20]);
        compare_field("o_dec.imm", dec.imm, exp_imm);
        compare_field("o_dec.rd_wen", dec.rd_wen, writes_rd(word, exp_cls));
        dec_pc = next_fetch_pc(dec_pc);
        records++;
      end
      post_cyc++;
    end
  end

  initial begin
    rst       = 1'b1;
    errors    = 0;
    records   = 0;
    cycles    = 0;
    post_cyc  = 0;
    clk       = 1'b0;
    lcg_state = 32'd37;
    req_pc    = rv_fe_pkg::PC_RESET;
    dec_pc    = rv_fe_pkg::PC_RESET;
    for (int i = 0; i < 1024; i++) begin
      image[i]     = build_word();
      u_sram.mem[i] = image[i];
    end
    repeat (3) @(posedge clk);
    #2 rst = 1'b0;
    while (records < NUM_RECORDS && cycles < MAX_CYCLES) begin
      @(posedge clk);
    end
    if (records < NUM_RECORDS) begin
      $display("timeout: decoding stalled after %0d records", records);
    end
    $display("errors: %0d, records checked: %0d", errors, records);
    if (errors == 0 && records == NUM_RECORDS) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* sim.f */
verilog/rv_fe_pkg.sv
verilog/rv_pc.sv
verilog/rv_if_stage.sv
verilog/rv_imm_gen.sv
verilog/rv_id_stage.sv
verilog/rv_frontend.sv
bench/inst_sram_model.sv
bench/tb_rv_frontend.sv
